/* hw/chordPkg.sv */
package chordPkg;

	// ------------------------------
	// Sizes
	// ------------------------------
	localparam int noteCount   = 4; // Notes per chord, one voice each
	localparam int chordCount  = 4; // Chord registers and chord keys
	localparam int stepsPerBar = 4; // Beats per bar, one pattern bit per beat

	// ------------------------------
	// Types
	// ------------------------------
	// One bit per note, bit n gates voice n
	typedef logic [noteCount-1:0] noteMask_t;

	// One bit per chord key
	typedef logic [chordCount-1:0] chordMask_t;

	// Rhythm pattern, played from the top bit down
	typedef logic [stepsPerBar-1:0] pattern_t;

	typedef logic signed [31:0] sample_t;  // Mixed audio sample
	typedef logic [7:0] halfPeriod_t;      // Voice half period in clocks
	typedef logic [15:0] beatCount_t;      // Beat timer count

	// ------------------------------
	// Timing and pitch
	// ------------------------------
	// Clocks per beat, scaled far below a real tempo
	localparam beatCount_t beatCycles = 16'd40;

	// Level magnitude of a single square voice
	localparam sample_t toneAmplitude = 32'sd20000000;

	// Half periods of the lowest note set, ratios kept close to C Eb F G
	localparam halfPeriod_t noteHalfPeriod0 = 8'd24; // C
	localparam halfPeriod_t noteHalfPeriod1 = 8'd20; // E flat
	localparam halfPeriod_t noteHalfPeriod2 = 8'd18; // F
	localparam halfPeriod_t noteHalfPeriod3 = 8'd16; // G

endpackage

/* hw/beatTimer.sv */
`timescale 1ns/1ps

module beatTimer (
	input  logic clk,
	input  logic reset,
	input  logic loopEnable,  // Looper running
	output logic beatStrobe,  // One cycle per beat
	output logic barStart     // With the strobe of the first beat in a bar
);
	import chordPkg::*;

	// ------------------------------
	// Beat counter
	// ------------------------------
	// Zero only while idle, then runs beatCycles down to 1
	beatCount_t count;

	// Position of the next strobe inside the bar
	logic [$clog2(stepsPerBar)-1:0] beatIndex;

	always_ff @(posedge clk) begin
		if (reset) begin
			count     <= '0;
			beatIndex <= '0;
		end else if (!loopEnable) begin
			count     <= '0; // Looper off, hold everything at the start of a bar
			beatIndex <= '0;
		end else begin
			if (count <= beatCount_t'(1))
				count <= beatCycles; // First high cycle or end of beat
			else
				count <= count - beatCount_t'(1);

			// Index moves on along with each strobe and wraps at the bar
			if (beatStrobe)
				beatIndex <= beatIndex + 1'b1;
		end
	end

	// ------------------------------
	// Strobes
	// ------------------------------
	// Count of 1 is the last clock of a beat, beatCycles after the reload
	assign beatStrobe = loopEnable && (count == beatCount_t'(1));

	// First beat of the bar
	assign barStart = beatStrobe && (beatIndex == '0);

endmodule

/* hw/loopSequencer.sv */
`timescale 1ns/1ps

module loopSequencer (
	input  logic clk,
	input  logic reset,
	input  logic loopEnable,
	input  logic beatStrobe,             // Advance one step
	input  logic barStart,               // Reload all patterns
	input  chordPkg::pattern_t pattern0, // Stored rhythm of chord 0
	input  chordPkg::pattern_t pattern1,
	input  chordPkg::pattern_t pattern2,
	input  chordPkg::pattern_t pattern3,
	output chordPkg::chordMask_t stepActive // Chord k plays on this beat
);
	import chordPkg::*;

	// Patterns gathered into one array, index is the chord
	pattern_t patterns [chordCount];

	// Working copies, the top bit is the current step
	pattern_t stepReg [chordCount];

	assign patterns[0] = pattern0;
	assign patterns[1] = pattern1;
	assign patterns[2] = pattern2;
	assign patterns[3] = pattern3;

	// ------------------------------
	// Step registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset || !loopEnable) begin
			// Looper off drops every looped chord
			for (int k = 0; k < chordCount; k++)
				stepReg[k] <= '0;
		end else if (barStart) begin
			// Bar start wins over the plain beat shift
			for (int k = 0; k < chordCount; k++)
				stepReg[k] <= patterns[k];
		end else if (beatStrobe) begin
			// Next lower bit moves up into the current step
			for (int k = 0; k < chordCount; k++)
				stepReg[k] <= {stepReg[k][stepsPerBar-2:0], 1'b0};
		end
	end

	// ------------------------------
	// Current step
	// ------------------------------
	// Pattern bits play in the order 3, 2, 1, 0 within a bar
	always_comb begin
		for (int k = 0; k < chordCount; k++)
			stepActive[k] = stepReg[k][stepsPerBar-1];
	end

endmodule

/* hw/chordStore.sv */
`timescale 1ns/1ps

module chordStore (
	input  logic clk,
	input  logic reset,
	input  logic loopEnable,                 // Loop mode, keys record rhythms
	input  chordPkg::chordMask_t chordKeys,  // Held chord keys, active high
	input  chordPkg::noteMask_t noteSwitches, // Notes or rhythm steps to capture
	output chordPkg::noteMask_t chordNotes0,  // Notes of chord 0
	output chordPkg::noteMask_t chordNotes1,
	output chordPkg::noteMask_t chordNotes2,
	output chordPkg::noteMask_t chordNotes3,
	output chordPkg::pattern_t pattern0,      // Rhythm of chord 0
	output chordPkg::pattern_t pattern1,
	output chordPkg::pattern_t pattern2,
	output chordPkg::pattern_t pattern3
);
	import chordPkg::*;

	// ------------------------------
	// Mode decode
	// ------------------------------
	// Write mode needs some note on, all switches off means play only
	logic writeMode;
	logic loopMode;

	assign writeMode = !loopEnable && (noteSwitches != '0);
	assign loopMode  = loopEnable;

	// Storage, one entry per chord key
	noteMask_t chordReg [chordCount];
	pattern_t patternReg [chordCount];

	// ------------------------------
	// Chord note registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < chordCount; k++)
				chordReg[k] <= '0;
		end else begin
			for (int k = 0; k < chordCount; k++) begin
				if (writeMode && chordKeys[k])
					chordReg[k] <= noteSwitches; // Several keys may take the same chord
			end
		end
	end

	// ------------------------------
	// Loop pattern registers
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			for (int k = 0; k < chordCount; k++)
				patternReg[k] <= '0;
		end else begin
			for (int k = 0; k < chordCount; k++) begin
				// Switch n becomes beat step n of the rhythm
				if (loopMode && chordKeys[k])
					patternReg[k] <= pattern_t'(noteSwitches);
			end
		end
	end

	// Outputs
	assign chordNotes0 = chordReg[0];
	assign chordNotes1 = chordReg[1];
	assign chordNotes2 = chordReg[2];
	assign chordNotes3 = chordReg[3];

	assign pattern0 = patternReg[0];
	assign pattern1 = patternReg[1];
	assign pattern2 = patternReg[2];
	assign pattern3 = patternReg[3];

endmodule

/* hw/squareVoice.sv */
`timescale 1ns/1ps

module squareVoice (
	input  logic clk,
	input  logic reset,
	input  chordPkg::halfPeriod_t halfPeriod, // Clocks per level, sets the pitch
	output logic level                        // Square wave, high or low half
);
	import chordPkg::*;

	// Clocks spent in the current half period
	halfPeriod_t count;

	// Last clock of the half period
	logic halfDone;

	assign halfDone = (count == halfPeriod - halfPeriod_t'(1));

	// ------------------------------
	// Free running oscillator
	// ------------------------------
	always_ff @(posedge clk) begin
		if (reset) begin
			count <= '0;
			level <= 1'b0; // Starts on the low half
		end else if (halfDone) begin
			count <= '0;
			level <= !level; // Flip each half period
		end else begin
			count <= count + halfPeriod_t'(1);
		end
	end

endmodule

/* hw/toneMixer.sv */
`timescale 1ns/1ps

module toneMixer (
	input  logic clk,
	input  logic reset,
	input  logic voiceEnable,                // Mutes the sample, gates still run
	input  chordPkg::chordMask_t chordKeys,  // Played by hand
	input  chordPkg::chordMask_t stepActive, // Played by the looper
	input  chordPkg::noteMask_t chordNotes0,
	input  chordPkg::noteMask_t chordNotes1,
	input  chordPkg::noteMask_t chordNotes2,
	input  chordPkg::noteMask_t chordNotes3,
	output chordPkg::noteMask_t noteGate,    // Notes now sounding
	output chordPkg::sample_t sample         // Mixed signed sample
);
	import chordPkg::*;

	noteMask_t notesOf [chordCount];  // Chord notes by chord index
	chordMask_t activeChords;         // Key held or looped step
	noteMask_t gateNext;              // Gates for the next cycle
	logic [noteCount-1:0] voiceLevel; // Square levels, one per note
	sample_t mixSum;                  // Signed sum of the gated voices

	assign notesOf[0] = chordNotes0;
	assign notesOf[1] = chordNotes1;
	assign notesOf[2] = chordNotes2;
	assign notesOf[3] = chordNotes3;

	// ------------------------------
	// Voices
	// ------------------------------
	squareVoice iVoice0 (.clk(clk), .reset(reset), .halfPeriod(noteHalfPeriod0),
		.level(voiceLevel[0]));
	squareVoice iVoice1 (.clk(clk), .reset(reset), .halfPeriod(noteHalfPeriod1),
		.level(voiceLevel[1]));
	squareVoice iVoice2 (.clk(clk), .reset(reset), .halfPeriod(noteHalfPeriod2),
		.level(voiceLevel[2]));
	squareVoice iVoice3 (.clk(clk), .reset(reset), .halfPeriod(noteHalfPeriod3),
		.level(voiceLevel[3]));

	// ------------------------------
	// Gating and mixing
	// ------------------------------
	assign activeChords = chordKeys | stepActive; // Hand and loop blend

	// Chords that share a note simply sound it once
	always_comb begin
		gateNext = '0;
		for (int k = 0; k < chordCount; k++) begin
			if (activeChords[k])
				gateNext = gateNext | notesOf[k];
		end
	end

	// Each gated voice adds plus or minus the amplitude
	always_comb begin
		mixSum = '0;
		for (int n = 0; n < noteCount; n++) begin
			if (gateNext[n])
				mixSum = voiceLevel[n] ? mixSum + toneAmplitude : mixSum - toneAmplitude;
		end
	end

	// Gate and sample leave on the same edge
	always_ff @(posedge clk) begin
		if (reset) begin
			noteGate <= '0;
			sample   <= '0;
		end else begin
			noteGate <= gateNext;
			sample   <= voiceEnable ? mixSum : '0; // Silent when voices are off
		end
	end

endmodule

/* hw/chordMachine.sv */
`timescale 1ns/1ps

module chordMachine (
	input  logic clk,
	input  logic reset,
	input  chordPkg::noteMask_t noteSwitches, // Notes to store, or rhythm steps
	input  chordPkg::chordMask_t chordKeys,   // Chord keys, active high
	input  logic loopEnable,                  // Looper mode
	input  logic voiceEnable,                 // Audio on
	output chordPkg::noteMask_t noteGate,     // Sounding notes
	output logic beatStrobe,
	output logic barStart,
	output chordPkg::sample_t sample
);
	import chordPkg::*;

	// ------------------------------
	// Internal wires
	// ------------------------------
	noteMask_t chordNotes0, chordNotes1, chordNotes2, chordNotes3; // Stored chords
	pattern_t pattern0, pattern1, pattern2, pattern3;             // Stored rhythms
	chordMask_t stepActive;                                        // Looped chords

	// Tempo
	beatTimer iBeatTimer (
		.clk        (clk),
		.reset      (reset),
		.loopEnable (loopEnable),
		.beatStrobe (beatStrobe),
		.barStart   (barStart)
	);

	// Chord and rhythm capture
	chordStore iChordStore (
		.clk          (clk),
		.reset        (reset),
		.loopEnable   (loopEnable),
		.chordKeys    (chordKeys),
		.noteSwitches (noteSwitches),
		.chordNotes0  (chordNotes0),
		.chordNotes1  (chordNotes1),
		.chordNotes2  (chordNotes2),
		.chordNotes3  (chordNotes3),
		.pattern0     (pattern0),
		.pattern1     (pattern1),
		.pattern2     (pattern2),
		.pattern3     (pattern3)
	);

	// Plays the stored rhythms
	loopSequencer iLoopSequencer (
		.clk        (clk),
		.reset      (reset),
		.loopEnable (loopEnable),
		.beatStrobe (beatStrobe),
		.barStart   (barStart),
		.pattern0   (pattern0),
		.pattern1   (pattern1),
		.pattern2   (pattern2),
		.pattern3   (pattern3),
		.stepActive (stepActive)
	);

	// Voices and sample
	toneMixer iToneMixer (
		.clk         (clk),
		.reset       (reset),
		.voiceEnable (voiceEnable),
		.chordKeys   (chordKeys),
		.stepActive  (stepActive),
		.chordNotes0 (chordNotes0),
		.chordNotes1 (chordNotes1),
		.chordNotes2 (chordNotes2),
		.chordNotes3 (chordNotes3),
		.noteGate    (noteGate),
		.sample      (sample)
	);

endmodule

/* test/chordMachine_properties.sv */
`timescale 1ns/1ps

module chordMachineProperties (
	input  logic clk,
	input  logic reset,
	input  logic loopEnable,
	input  logic voiceEnable,
	input  logic beatStrobe,
	input  logic barStart,
	input  chordPkg::sample_t sample
);

	// ------------------------------
	// Beat strobes
	// ------------------------------
	strobeSingle: assert property (@(posedge clk) disable iff (reset) beatStrobe |=> !beatStrobe)
		else $error("beatStrobe high for more than one cycle");

	barSingle: assert property (@(posedge clk) disable iff (reset) barStart |=> !barStart)
		else $error("barStart high for more than one cycle");

	// Bar start only rides on a beat
	barWithBeat: assert property (@(posedge clk) disable iff (reset) barStart |-> beatStrobe)
		else $error("barStart without beatStrobe");

	idleQuiet: assert property (@(posedge clk) disable iff (reset)
		!loopEnable |-> (!beatStrobe && !barStart))
		else $error("strobe while looper is off");

	// Sample is registered, so the mute shows one edge later
	mutedSample: assert property (@(posedge clk) disable iff (reset) !voiceEnable |=> sample == 0)
		else $error("sample not zero while voices are off");

endmodule

bind chordMachine chordMachineProperties iProperties (.*);

/* test/chordMachineTb.sv */
`timescale 1ns/1ps

module chordMachineTb;

	localparam int beatLen     = 40;       // Clocks per beat
	localparam int amplitude   = 20000000; // Level of one voice
	localparam int stepTimeout = 200;      // Cycle limit of each wait

	logic clk = 1'b0;
	logic reset;
	logic [3:0] noteSwitches;
	logic [3:0] chordKeys;
	logic loopEnable;
	logic voiceEnable;
	logic [3:0] noteGate;
	logic beatStrobe;
	logic barStart;
	logic signed [31:0] sample;

	// Input values for the next rising edge
	logic nextReset;
	logic [3:0] nextSwitches;
	logic [3:0] nextKeys;
	logic nextLoop;
	logic nextVoice;

	// ------------------------------
	// Model state
	// ------------------------------
	int phase;                 // Looper cycles since loopEnable rose
	logic [3:0] modelStep [4]; // Step shifters whose top bit plays
	logic [3:0] modelChord [4];
	logic [3:0] modelPattern [4];
	int voiceCount [4];
	logic [3:0] voiceLevel;
	logic [3:0] modelGate;
	int modelSample;

	logic [3:0] written [4];  // Chords as the test wrote them
	logic [3:0] captured [4]; // Patterns as the test recorded them
	int errorCount = 0;
	int testCount = 0;
	int passCount = 0;

	chordMachine i_dut (
		.clk          (clk),
		.reset        (reset),
		.noteSwitches (noteSwitches),
		.chordKeys    (chordKeys),
		.loopEnable   (loopEnable),
		.voiceEnable  (voiceEnable),
		.noteGate     (noteGate),
		.beatStrobe   (beatStrobe),
		.barStart     (barStart),
		.sample       (sample)
	);

	always #2 clk = ~clk; // 4 ns period

	function automatic int halfPeriodOf(input int n);
		case (n)
			0: return 24; // C
			1: return 20; // E flat
			2: return 18; // F
			default: return 16; // G
		endcase
	endfunction

	// Beat n ends after n * beatLen looper cycles
	function automatic logic modelStrobe();
		return loopEnable && phase > 0 && (phase % beatLen) == 0;
	endfunction

	function automatic logic modelBar();
		return modelStrobe() && ((phase / beatLen - 1) % 4) == 0; // Beats 1, 5, 9 and so on
	endfunction

	function automatic logic [3:0] orOfWritten(input logic [3:0] keys);
		logic [3:0] gate;
		gate = '0;
		for (int k = 0; k < 4; k++)
			if (keys[k])
				gate = gate | written[k];
		return gate;
	endfunction

	// Expected gate for a beat of the bar with no keys held
	function automatic logic [3:0] loopedGate(input int beat);
		logic [3:0] gate;
		gate = '0;
		for (int k = 0; k < 4; k++)
			if (captured[k][3 - beat])
				gate = gate | written[k];
		return gate;
	endfunction

	task automatic resetModel();
		phase = 0;
		voiceLevel = '0;
		modelGate = '0;
		modelSample = 0;
		for (int k = 0; k < 4; k++) begin
			modelStep[k] = '0;
			modelChord[k] = '0;
			modelPattern[k] = '0;
			voiceCount[k] = 0;
		end
	endtask

	// ------------------------------
	// One clock edge of the model
	// ------------------------------
	task automatic updateModel();
		logic [3:0] gateNext;
		logic strobe;
		logic bar;
		int mix;
		if (reset) begin
			resetModel();
			return;
		end
		strobe = modelStrobe();
		bar = modelBar();
		gateNext = '0;
		for (int k = 0; k < 4; k++)
			if (chordKeys[k] || modelStep[k][3])
				gateNext = gateNext | modelChord[k]; // Hand or looper
		mix = 0;
		for (int n = 0; n < 4; n++)
			if (gateNext[n])
				mix = voiceLevel[n] ? mix + amplitude : mix - amplitude;
		modelGate = gateNext;
		modelSample = voiceEnable ? mix : 0;
		for (int n = 0; n < 4; n++) begin
			if (voiceCount[n] == halfPeriodOf(n) - 1) begin
				voiceCount[n] = 0;
				voiceLevel[n] = !voiceLevel[n];
			end else begin
				voiceCount[n]++;
			end
		end
		// Steps load the old patterns before the store writes new ones
		for (int k = 0; k < 4; k++) begin
			if (!loopEnable)
				modelStep[k] = '0;
			else if (bar)
				modelStep[k] = modelPattern[k];
			else if (strobe)
				modelStep[k] = {modelStep[k][2:0], 1'b0};
			if (!loopEnable && noteSwitches != '0 && chordKeys[k])
				modelChord[k] = noteSwitches;
			if (loopEnable && chordKeys[k])
				modelPattern[k] = noteSwitches;
		end
		phase = loopEnable ? phase + 1 : 0;
	endtask

	task automatic checkOutputs();
		assert (noteGate === modelGate) else begin
			$display("CHECK FAILED at %0t: noteGate %h, expected %h", $time, noteGate, modelGate);
			errorCount++;
		end
		assert (sample === modelSample) else begin
			$display("CHECK FAILED at %0t: sample %0d, expected %0d", $time, sample, modelSample);
			errorCount++;
		end
		assert (beatStrobe === modelStrobe() && barStart === modelBar()) else begin
			$display("CHECK FAILED at %0t: strobes %b%b, expected %b%b", $time, beatStrobe,
				barStart, modelStrobe(), modelBar());
			errorCount++;
		end
	endtask

	// Drive on the rising edge, compare at the falling edge
	task automatic stepCycle();
		@(posedge clk);
		updateModel();
		reset        <= nextReset;
		noteSwitches <= nextSwitches;
		chordKeys    <= nextKeys;
		loopEnable   <= nextLoop;
		voiceEnable  <= nextVoice;
		@(negedge clk);
		checkOutputs();
	endtask

	task automatic waitStrobe(output int cycles);
		cycles = 0;
		while (cycles < stepTimeout) begin
			stepCycle();
			cycles++;
			if (beatStrobe)
				return;
		end
		$display("timeout: no beat strobe within %0d cycles at %0t", stepTimeout, $time);
		errorCount++;
	endtask

	task automatic finishTest(input string name, input int errorsBefore);
		testCount++;
		if (errorCount == errorsBefore) begin
			passCount++;
			$display("test %s: passed", name);
		end else begin
			$display("test %s: failed with %0d errors", name, errorCount - errorsBefore);
		end
	endtask

	initial begin
		int cycles;
		int errorsBefore;
		int strobeSeen;
		void'($urandom(75));
		reset = 1'b1;
		noteSwitches = '0;
		chordKeys = '0;
		loopEnable = 1'b0;
		voiceEnable = 1'b0;
		nextReset = 1'b1;
		nextSwitches = '0;
		nextKeys = '0;
		nextLoop = 1'b0;
		nextVoice = 1'b0;
		resetModel();
		for (int k = 0; k < 4; k++) begin
			written[k] = '0;
			captured[k] = '0;
		end
		repeat (15) stepCycle(); // 16 edges with reset high
		nextReset = 1'b0;

		// ------------------------------
		// Quiet after reset
		errorsBefore = errorCount;
		repeat (20) begin
			stepCycle();
			assert (noteGate === '0 && sample === 0 && !beatStrobe && !barStart) else begin
				$display("CHECK FAILED at %0t: outputs active after reset", $time);
				errorCount++;
			end
		end
		finishTest("resetState", errorsBefore);

		// Write chords, then play them by hand
		errorsBefore = errorCount;
		for (int i = 0; i < 8; i++) begin
			nextSwitches = 4'($urandom_range(15, 1));
			nextKeys = 4'(1 << $urandom_range(3, 0));
			stepCycle();
			for (int k = 0; k < 4; k++)
				if (nextKeys[k])
					written[k] = nextSwitches;
		end
		nextSwitches = '0;
		repeat (12) begin
			nextKeys = 4'($urandom_range(15, 0));
			stepCycle();
			stepCycle(); // Gate is one register late
			assert (noteGate === orOfWritten(chordKeys)) else begin
				$display("CHECK FAILED at %0t: noteGate %h for keys %b", $time, noteGate, chordKeys);
				errorCount++;
			end
		end
		finishTest("chordWrite", errorsBefore);

		// Voices on, then muted
		errorsBefore = errorCount;
		nextVoice = 1'b1;
		repeat (40) begin
			nextKeys = 4'($urandom_range(15, 0));
			repeat (5) stepCycle();
		end
		nextVoice = 1'b0;
		stepCycle();
		for (int i = 0; i < 60; i++) begin
			if (i % 6 == 0)
				nextKeys = 4'($urandom_range(15, 0));
			stepCycle();
			assert (sample === 0) else begin
				$display("CHECK FAILED at %0t: sample %0d while muted", $time, sample);
				errorCount++;
			end
		end
		finishTest("sampleMix", errorsBefore);

		// ------------------------------
		// Beat and bar timing
		errorsBefore = errorCount;
		nextKeys = '0;
		nextVoice = 1'b1;
		nextLoop = 1'b1;
		stepCycle(); // First looper cycle
		for (int s = 0; s < 12; s++) begin
			waitStrobe(cycles);
			assert (cycles == beatLen) else begin
				$display("CHECK FAILED at %0t: beat after %0d cycles", $time, cycles);
				errorCount++;
			end
			assert (barStart === (s % 4 == 0)) else begin
				$display("CHECK FAILED at %0t: barStart %b on beat %0d", $time, barStart, s);
				errorCount++;
			end
		end
		finishTest("beatTiming", errorsBefore);

		// Record one pattern per chord, then follow a bar
		errorsBefore = errorCount;
		for (int k = 0; k < 4; k++) begin
			nextSwitches = 4'($urandom_range(15, 0));
			nextKeys = 4'(1 << k);
			stepCycle();
			captured[k] = nextSwitches;
		end
		nextKeys = '0;
		nextSwitches = '0;
		waitStrobe(cycles);
		for (int s = 0; s < 4 && !barStart; s++)
			waitStrobe(cycles);
		for (int beat = 0; beat < 4; beat++) begin
			if (beat > 0)
				waitStrobe(cycles);
			stepCycle();
			stepCycle(); // Step register, then gate register
			assert (noteGate === loopedGate(beat)) else begin
				$display("CHECK FAILED at %0t: noteGate %h on beat %0d", $time, noteGate, beat);
				errorCount++;
			end
		end
		repeat (4 * beatLen) stepCycle();
		finishTest("loopPattern", errorsBefore);

		// Looper off in the middle of a bar
		errorsBefore = errorCount;
		waitStrobe(cycles);
		for (int s = 0; s < 4 && barStart; s++)
			waitStrobe(cycles);
		nextLoop = 1'b0;
		nextKeys = 4'($urandom_range(15, 1));
		strobeSeen = 0;
		for (int i = 0; i < 100; i++) begin
			stepCycle();
			if (beatStrobe || barStart)
				strobeSeen++;
			if (i >= 2) begin
				assert (noteGate === orOfWritten(chordKeys)) else begin
					$display("CHECK FAILED at %0t: noteGate %h after loop stop", $time, noteGate);
					errorCount++;
				end
			end
		end
		assert (strobeSeen == 0) else begin
			$display("CHECK FAILED at %0t: %0d strobes with looper off", $time, strobeSeen);
			errorCount++;
		end
		finishTest("loopDrop", errorsBefore);

		$display("tests run %0d, passed %0d, failed %0d", testCount, passCount,
			testCount - passCount);
		if (errorCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

/* chordMachine.f */
hw/chordPkg.sv
hw/beatTimer.sv
hw/loopSequencer.sv
hw/chordStore.sv
hw/squareVoice.sv
hw/toneMixer.sv
hw/chordMachine.sv
test/chordMachine_properties.sv
test/chordMachineTb.sv
